//--- hdl/predictorPkg.sv
package predictorPkg;

    // Instruction address width in bits
    localparam int addrWidth = 32;

    // Number of resolved outcomes kept in the global history
    localparam int historyWidth = 2;

    // One pattern bank per history value
    localparam int bankCount = 1 << historyWidth;

    // Global history of the last two conditional branches
    // Left letter is the older outcome (U untaken, T taken)
    // Encoded value doubles as the pattern bank number
    typedef enum logic [historyWidth-1:0] {
        historyUU = 2'b00,
        historyUT = 2'b01,
        historyTU = 2'b10,
        historyTT = 2'b11
    } historyState;

    // Two-bit saturating direction counter
    // High bit gives the predicted direction
    typedef enum logic [1:0] {
        strongNotTaken = 2'b00,
        weakNotTaken   = 2'b01,
        weakTaken      = 2'b10,
        strongTaken    = 2'b11
    } counterState;

endpackage

//--- hdl/pipelinePkg.sv
package pipelinePkg;

    // Fetch stage request, one lookup per cycle
    typedef struct packed {
        logic [predictorPkg::addrWidth-1:0] pc;
    } fetchQuery;

    // Answer returned to fetch in the same cycle
    typedef struct packed {
        // Redirect fetch to predictTarget
        logic                               predictTaken;
        // Target buffer holds this PC
        logic                               targetHit;
        logic [predictorPkg::addrWidth-1:0] predictTarget;
    } prediction;

    // Outcome of the branch sitting in execute
    typedef struct packed {
        // Conditional branch present in execute
        logic                               isBranch;
        // Resolved direction
        logic                               taken;
        // Execute held this cycle, resolve not accepted
        logic                               stall;
        logic [predictorPkg::addrWidth-1:0] branchPc;
        // Computed taken target
        logic [predictorPkg::addrWidth-1:0] branchTarget;
    } branchResolve;

endpackage

//--- hdl/branchHistory.sv
`timescale 1ns/100ps

module branchHistory (
    input  logic                      clk,
    input  logic                      reset,

    // Accepted resolve from execute
    input  logic                      resolveFire,
    // Direction of the resolved branch
    input  logic                      outcome,

    // Registered global history
    output predictorPkg::historyState history
);

    predictorPkg::historyState nextHistory;

    // Next state logic
    // Newer bit moves to the older slot, outcome fills the newer slot
    always_comb begin
        nextHistory = history;
        if (resolveFire) begin
            case (history)
                predictorPkg::historyUU: begin
                    nextHistory = outcome ? predictorPkg::historyUT : predictorPkg::historyUU;
                end
                predictorPkg::historyUT: begin
                    nextHistory = outcome ? predictorPkg::historyTT : predictorPkg::historyTU;
                end
                predictorPkg::historyTU: begin
                    nextHistory = outcome ? predictorPkg::historyUT : predictorPkg::historyUU;
                end
                predictorPkg::historyTT: begin
                    nextHistory = outcome ? predictorPkg::historyTT : predictorPkg::historyTU;
                end
                default: begin
                    // Unreachable with a two-bit enum
                    nextHistory = predictorPkg::historyUT;
                end
            endcase
        end
    end

    // State register, also the block output
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            // Start with a weak taken bias in the newer slot
            history <= predictorPkg::historyUT;
        end else begin
            history <= nextHistory;
        end
    end

endmodule

//--- hdl/patternTables.sv
`timescale 1ns/100ps

module patternTables #(
    // Entries per bank as a power of two
    parameter int indexBits = 4
) (
    input  logic                               clk,
    input  logic                               reset,

    // Bank select for both read and training
    input  predictorPkg::historyState          history,

    // Fetch side read
    input  logic [predictorPkg::addrWidth-1:0] lookupPc,

    // Execute side training
    input  logic                               resolveFire,
    input  logic [predictorPkg::addrWidth-1:0] updatePc,
    input  logic                               outcome,

    // Direction bit of the selected counter
    output logic                               predictTaken
);

    localparam int entryCount = 1 << indexBits;

    predictorPkg::counterState counters [predictorPkg::bankCount][entryCount];

    logic [indexBits-1:0]      lookupIndex;
    logic [indexBits-1:0]      updateIndex;
    predictorPkg::counterState lookupCounter;
    predictorPkg::counterState updateCounter;

    // One saturating step toward the resolved direction
    function automatic predictorPkg::counterState stepCounter(
        input predictorPkg::counterState current,
        input logic                      taken
    );
        predictorPkg::counterState stepped;
        case (current)
            predictorPkg::strongNotTaken: begin
                stepped = taken ? predictorPkg::weakNotTaken : predictorPkg::strongNotTaken;
            end
            predictorPkg::weakNotTaken: begin
                stepped = taken ? predictorPkg::weakTaken : predictorPkg::strongNotTaken;
            end
            predictorPkg::weakTaken: begin
                stepped = taken ? predictorPkg::strongTaken : predictorPkg::weakNotTaken;
            end
            default: begin
                stepped = taken ? predictorPkg::strongTaken : predictorPkg::weakTaken;
            end
        endcase
        return stepped;
    endfunction

    // Word index just above the byte offset
    assign lookupIndex = lookupPc[indexBits+1:2];
    assign updateIndex = updatePc[indexBits+1:2];

    // Combinational read, sees the old value on a same-cycle write
    assign lookupCounter = counters[history][lookupIndex];
    assign predictTaken  = lookupCounter[1];

    // Trained entry uses history from before this edge's shift
    assign updateCounter = counters[history][updateIndex];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int bank = 0; bank < predictorPkg::bankCount; bank++) begin
                for (int entry = 0; entry < entryCount; entry++) begin
                    counters[bank][entry] <= predictorPkg::weakNotTaken;
                end
            end
        end else if (resolveFire) begin
            counters[history][updateIndex] <= stepCounter(updateCounter, outcome);
        end
    end

endmodule

//--- hdl/targetBuffer.sv
`timescale 1ns/100ps

module targetBuffer #(
    // Entries as a power of two
    parameter int indexBits = 4,
    parameter int tagBits   = 8
) (
    input  logic                               clk,
    input  logic                               reset,

    // Fetch side read
    input  logic [predictorPkg::addrWidth-1:0] lookupPc,
    output logic                               hit,
    output logic [predictorPkg::addrWidth-1:0] target,

    // Execute side fill
    input  logic                               resolveFire,
    input  logic                               updateTaken,
    input  logic [predictorPkg::addrWidth-1:0] updatePc,
    input  logic [predictorPkg::addrWidth-1:0] updateTarget
);

    localparam int entryCount = 1 << indexBits;

    // Payload of one buffer line
    typedef struct packed {
        logic [tagBits-1:0]                 tag;
        logic [predictorPkg::addrWidth-1:0] target;
    } bufferEntry;

    logic       valid   [entryCount];
    bufferEntry entries [entryCount];

    logic [indexBits-1:0] lookupIndex;
    logic [tagBits-1:0]   lookupTag;
    logic [indexBits-1:0] updateIndex;
    logic [tagBits-1:0]   updateTag;
    bufferEntry           lookupEntry;
    logic                 writeEnable;

    // Index above the byte offset, tag directly above the index
    assign lookupIndex = lookupPc[indexBits+1:2];
    assign lookupTag   = lookupPc[indexBits+2 +: tagBits];
    assign updateIndex = updatePc[indexBits+1:2];
    assign updateTag   = updatePc[indexBits+2 +: tagBits];

    assign lookupEntry = entries[lookupIndex];
    assign hit         = valid[lookupIndex] && (lookupEntry.tag == lookupTag);
    // Zero target on a miss keeps stale lines off the bus
    assign target      = hit ? lookupEntry.target : '0;

    // Only taken branches allocate
    assign writeEnable = resolveFire && updateTaken;

    // Valid bits
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int entry = 0; entry < entryCount; entry++) begin
                valid[entry] <= 1'b0;
            end
        end else if (writeEnable) begin
            valid[updateIndex] <= 1'b1;
        end
    end

    // Tag and target, earlier occupant simply overwritten
    always_ff @(posedge clk) begin
        if (writeEnable) begin
            entries[updateIndex] <= '{tag: updateTag, target: updateTarget};
        end
    end

endmodule

//--- hdl/branchPredictor.sv
`timescale 1ns/100ps

module branchPredictor #(
    parameter int indexBits = 4,
    parameter int tagBits   = 8
) (
    input  logic                      clk,
    input  logic                      reset,

    // Fetch stage
    input  pipelinePkg::fetchQuery    query,
    output pipelinePkg::prediction    pred,

    // Execute stage
    input  pipelinePkg::branchResolve resolve,

    // Current history for debug and flush logic
    output predictorPkg::historyState history
);

    logic                               resolveFire;
    logic                               counterTaken;
    logic                               targetHit;
    logic [predictorPkg::addrWidth-1:0] predictTarget;

    // Single accept condition shared by all three blocks
    assign resolveFire = resolve.isBranch & ~resolve.stall;

    branchHistory history_i (
        .clk         (clk),
        .reset       (reset),
        .resolveFire (resolveFire),
        .outcome     (resolve.taken),
        .history     (history)
    );

    patternTables #(
        .indexBits (indexBits)
    ) patternTables_i (
        .clk          (clk),
        .reset        (reset),
        .history      (history),
        .lookupPc     (query.pc),
        .resolveFire  (resolveFire),
        .updatePc     (resolve.branchPc),
        .outcome      (resolve.taken),
        .predictTaken (counterTaken)
    );

    targetBuffer #(
        .indexBits (indexBits),
        .tagBits   (tagBits)
    ) targetBuffer_i (
        .clk          (clk),
        .reset        (reset),
        .lookupPc     (query.pc),
        .hit          (targetHit),
        .target       (predictTarget),
        .resolveFire  (resolveFire),
        .updateTaken  (resolve.taken),
        .updatePc     (resolve.branchPc),
        .updateTarget (resolve.branchTarget)
    );

    // Taken only with a known target to redirect to
    assign pred.predictTaken  = counterTaken & targetHit;
    assign pred.targetHit     = targetHit;
    assign pred.predictTarget = predictTarget;

endmodule

//--- bench/branchPredictor_chk.sv
`timescale 1ns/100ps

module branchPredictorChk (
    input logic                      clk,
    input logic                      reset,
    input pipelinePkg::branchResolve resolve,
    input pipelinePkg::prediction    pred,
    input predictorPkg::historyState history
);

    logic resolveFire;

    // Same accept condition as the top level
    assign resolveFire = resolve.isBranch && !resolve.stall;

    // History leaves reset as UT
    resetHistory: assert property (@(posedge clk)
        $fell(reset) |-> history == predictorPkg::historyUT)
        else $error("history is not historyUT after reset");

    // No redirect without a buffered target
    takenNeedsHit: assert property (@(posedge clk) disable iff (reset)
        pred.predictTaken |-> pred.targetHit)
        else $error("predictTaken is high without targetHit");

    // Stalled or non-branch cycles hold history
    idleHoldsHistory: assert property (@(posedge clk) disable iff (reset)
        !resolveFire |=> $stable(history))
        else $error("history changed without an accepted resolve");

    // Newer slot gets the resolved outcome
    newerBitIsOutcome: assert property (@(posedge clk) disable iff (reset)
        resolveFire |=> history[0] == $past(resolve.taken))
        else $error("newer history bit differs from the resolved outcome");

endmodule

bind branchPredictor branchPredictorChk chk_i (
    .clk     (clk),
    .reset   (reset),
    .resolve (resolve),
    .pred    (pred),
    .history (history)
);

//--- bench/branchPredictorTb.sv
`timescale 1ns/100ps

module branchPredictorTb;

    localparam int indexBits   = 4;
    localparam int tagBits     = 8;
    localparam int addrWidth   = predictorPkg::addrWidth;
    localparam int entryCount  = 1 << indexBits;
    localparam int clkPeriod   = 20;
    localparam int resetCycles = 10;
    localparam int mixCount    = 40;
    // Cycles per test in run order
    localparam int testCycles  = resetCycles + 8 + 12 + 6 + 4 * 6 * 11 + 10 + mixCount * 4;

    logic                      clk;
    logic                      reset;
    pipelinePkg::fetchQuery    query;
    pipelinePkg::branchResolve resolve;
    pipelinePkg::prediction    pred;
    predictorPkg::historyState history;

    // Reference model
    predictorPkg::historyState modelHistory;
    predictorPkg::counterState modelCounters [predictorPkg::bankCount][entryCount];
    logic                      modelValid [entryCount];
    logic [tagBits-1:0]        modelTag [entryCount];
    logic [addrWidth-1:0]      modelTarget [entryCount];

    int errorCount;
    int seed;

    branchPredictor #(
        .indexBits (indexBits),
        .tagBits   (tagBits)
    ) dut_i (
        .clk     (clk),
        .reset   (reset),
        .query   (query),
        .pred    (pred),
        .resolve (resolve),
        .history (history)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clkPeriod / 2) clk = ~clk;
        end
    end

    // Watchdog over the whole test budget plus margin
    initial begin
        #((testCycles + 50) * clkPeriod);
        $display("Timeout, tests did not finish within %0d cycles", testCycles + 50);
        $display("Some tests failed");
        $finish;
    end

    function automatic logic [indexBits-1:0] pcIndex(input logic [addrWidth-1:0] pc);
        return pc[indexBits+1:2];
    endfunction

    function automatic logic [tagBits-1:0] pcTag(input logic [addrWidth-1:0] pc);
        return pc[indexBits+2 +: tagBits];
    endfunction

    function automatic logic [addrWidth-1:0] makePc(input logic [tagBits-1:0] tag,
                                                    input logic [indexBits-1:0] index);
        return {{(addrWidth - tagBits - indexBits - 2){1'b0}}, tag, index, 2'b00};
    endfunction

    // Saturating step toward the outcome
    function automatic predictorPkg::counterState trainCounter(
        input predictorPkg::counterState current,
        input logic                      taken
    );
        if (taken && current != predictorPkg::strongTaken) begin
            return predictorPkg::counterState'(current + 2'd1);
        end else if (!taken && current != predictorPkg::strongNotTaken) begin
            return predictorPkg::counterState'(current - 2'd1);
        end
        return current;
    endfunction

    function automatic pipelinePkg::prediction expectedPred(input logic [addrWidth-1:0] pc);
        logic [indexBits-1:0]   index;
        logic                   hitFlag;
        pipelinePkg::prediction expected;
        index = pcIndex(pc);
        hitFlag = modelValid[index] && (modelTag[index] == pcTag(pc));
        expected.targetHit = hitFlag;
        expected.predictTarget = hitFlag ? modelTarget[index] : '0;
        expected.predictTaken = hitFlag && modelCounters[modelHistory][index][1];
        return expected;
    endfunction

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        assert (actual === expected) else begin
            errorCount++;
            $display("Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic checkHistory(input predictorPkg::historyState expected);
        assert (history === expected) else begin
            errorCount++;
            $display("Error: history expected %h actual %h", expected, history);
        end
    endtask

    task automatic checkPred(input pipelinePkg::prediction expected);
        checkFlag("pred.predictTaken", expected.predictTaken, pred.predictTaken);
        checkFlag("pred.targetHit", expected.targetHit, pred.targetHit);
        assert (pred.predictTarget === expected.predictTarget) else begin
            errorCount++;
            $display("Error: pred.predictTarget expected %h actual %h",
                     expected.predictTarget, pred.predictTarget);
        end
    endtask

    // One cycle of fetch lookup checked mid-cycle
    task automatic lookupCheck(input logic [addrWidth-1:0] pc);
        @(posedge clk);
        query <= '{pc: pc};
        @(negedge clk);
        checkPred(expectedPred(pc));
    endtask

    // Present a resolve for one edge then retire it
    task automatic resolveBranch(input logic [addrWidth-1:0] pc,
                                 input logic [addrWidth-1:0] target,
                                 input logic taken, input logic asBranch, input logic stalled);
        logic [indexBits-1:0] index;
        index = pcIndex(pc);
        @(posedge clk);
        resolve <= '{isBranch: asBranch, taken: taken, stall: stalled,
                     branchPc: pc, branchTarget: target};
        @(posedge clk);
        resolve.isBranch <= 1'b0;
        if (asBranch && !stalled) begin
            // Counter trains in the bank held before the shift
            modelCounters[modelHistory][index] =
                trainCounter(modelCounters[modelHistory][index], taken);
            if (taken) begin
                modelValid[index] = 1'b1;
                modelTag[index] = pcTag(pc);
                modelTarget[index] = target;
            end
            modelHistory = predictorPkg::historyState'({modelHistory[0], taken});
        end
        @(negedge clk);
        checkHistory(modelHistory);
    endtask

    // Two resolves shift the wanted state in
    task automatic setHistory(input logic [addrWidth-1:0] pc,
                              input predictorPkg::historyState state);
        resolveBranch(pc, 32'h0000_4000, state[1], 1'b1, 1'b0);
        resolveBranch(pc, 32'h0000_4000, state[0], 1'b1, 1'b0);
        checkHistory(state);
    endtask

    task automatic resetStateTest();
        repeat (8) begin
            lookupCheck($random(seed));
            checkFlag("pred.targetHit", 1'b0, pred.targetHit);
            checkFlag("pred.predictTaken", 1'b0, pred.predictTaken);
        end
        checkHistory(predictorPkg::historyUT);
    endtask

    // Starts at UT and visits every state
    task automatic historySequenceTest();
        logic [addrWidth-1:0] pc;
        pc = makePc(8'h03, 4'h3);
        resolveBranch(pc, 32'h0000_1000, 1'b1, 1'b1, 1'b0);
        checkHistory(predictorPkg::historyTT);
        resolveBranch(pc, 32'h0000_1000, 1'b0, 1'b1, 1'b0);
        checkHistory(predictorPkg::historyTU);
        resolveBranch(pc, 32'h0000_1000, 1'b0, 1'b1, 1'b0);
        checkHistory(predictorPkg::historyUU);
        resolveBranch(pc, 32'h0000_1000, 1'b1, 1'b1, 1'b0);
        checkHistory(predictorPkg::historyUT);
        resolveBranch(pc, 32'h0000_1000, 1'b0, 1'b1, 1'b0);
        checkHistory(predictorPkg::historyTU);
        resolveBranch(pc, 32'h0000_1000, 1'b1, 1'b1, 1'b0);
        checkHistory(predictorPkg::historyUT);
    endtask

    task automatic filterTest();
        logic [addrWidth-1:0] pc;
        pc = makePc(8'h04, 4'h4);
        lookupCheck(pc);
        // Stalled resolve then a non-branch
        resolveBranch(pc, 32'h0000_2000, 1'b1, 1'b1, 1'b1);
        resolveBranch(pc, 32'h0000_2000, 1'b1, 1'b0, 1'b0);
        lookupCheck(pc);
        checkFlag("pred.targetHit", 1'b0, pred.targetHit);
    endtask

    task automatic counterBankTest();
        logic [addrWidth-1:0]      primePc;
        logic [addrWidth-1:0]      trainPc;
        predictorPkg::historyState bank;
        primePc = makePc(8'h05, 4'h1);
        trainPc = makePc(8'h06, 4'h2);
        for (int b = 0; b < predictorPkg::bankCount; b++) begin
            bank = predictorPkg::historyState'(b[1:0]);
            // Three taken then three untaken with direction on through step 3
            for (int step = 0; step < 6; step++) begin
                setHistory(primePc, bank);
                resolveBranch(trainPc, 32'h0000_3000, step < 3, 1'b1, 1'b0);
                setHistory(primePc, bank);
                lookupCheck(trainPc);
                checkFlag("pred.predictTaken", step < 4, pred.predictTaken);
            end
        end
    endtask

    task automatic targetBufferTest();
        logic [addrWidth-1:0] pcA;
        logic [addrWidth-1:0] pcB;
        logic [addrWidth-1:0] pcC;
        // A and B share index 9
        pcA = makePc(8'h21, 4'h9);
        pcB = makePc(8'h42, 4'h9);
        pcC = makePc(8'h07, 4'hA);
        resolveBranch(pcC, 32'h0000_5000, 1'b0, 1'b1, 1'b0);
        lookupCheck(pcC);
        checkFlag("pred.targetHit", 1'b0, pred.targetHit);
        resolveBranch(pcA, 32'h0000_6000, 1'b1, 1'b1, 1'b0);
        lookupCheck(pcA);
        checkFlag("pred.targetHit", 1'b1, pred.targetHit);
        resolveBranch(pcB, 32'h0000_7000, 1'b1, 1'b1, 1'b0);
        lookupCheck(pcB);
        checkFlag("pred.targetHit", 1'b1, pred.targetHit);
        lookupCheck(pcA);
        checkFlag("pred.targetHit", 1'b0, pred.targetHit);
    endtask

    task automatic randomMixTest();
        logic [addrWidth-1:0] pcSet [8];
        logic [addrWidth-1:0] targetSet [8];
        logic [31:0]          draw;
        for (int i = 0; i < 8; i++) begin
            draw = $random(seed);
            pcSet[i] = makePc(tagBits'(draw[8]), draw[indexBits-1:0]);
            draw = $random(seed);
            targetSet[i] = {draw[31:2], 2'b00};
        end
        repeat (mixCount) begin
            draw = $random(seed);
            // About one resolve in four stalls
            resolveBranch(pcSet[draw[2:0]], targetSet[draw[2:0]], draw[4], 1'b1,
                          draw[5] & draw[6]);
            lookupCheck(pcSet[draw[9:7]]);
            lookupCheck(pcSet[draw[12:10]]);
        end
    endtask

    initial begin
        seed = 93583;
        errorCount = 0;
        reset <= 1'b1;
        query <= '0;
        resolve <= '0;
        modelHistory = predictorPkg::historyUT;
        for (int entry = 0; entry < entryCount; entry++) begin
            for (int bank = 0; bank < predictorPkg::bankCount; bank++) begin
                modelCounters[bank][entry] = predictorPkg::weakNotTaken;
            end
            modelValid[entry] = 1'b0;
            modelTag[entry] = '0;
            modelTarget[entry] = '0;
        end
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
        resetStateTest();
        historySequenceTest();
        filterTest();
        counterBankTest();
        targetBufferTest();
        randomMixTest();
        $display("Checks finished with %0d errors", errorCount);
        if (errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- branchPredictor.f
hdl/predictorPkg.sv
hdl/pipelinePkg.sv
hdl/branchHistory.sv
hdl/patternTables.sv
hdl/targetBuffer.sv
hdl/branchPredictor.sv
bench/branchPredictor_chk.sv
bench/branchPredictorTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= branchPredictorTb
FILELIST  ?= branchPredictor.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_TEXT ?= Some tests failed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# A simulator abort also counts as failure
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_TEXT)" >> $(LOG)
	cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
